// File: design/pokey_io_pkg.sv
/* shared sizes, scan limits and enums for the pokey i/o section
   imported by every rtl block and by the testbench */
package pokey_io_pkg;

    localparam int KEY_BITS = 6;  // 64 key matrix
    localparam int NUM_POTS = 8;  // paddle lines
    localparam int POT_BITS = 8;  // pot counter and pot value width

    // scan limits
    localparam logic [KEY_BITS-1:0] KEY_LAST = 6'd63;   // last code of a keyboard pass
    localparam logic [POT_BITS-1:0] POT_MAX  = 8'd228;  // last line count of a pot scan

    // cpu register map, 4 bit address
    typedef enum logic [3:0] {
        POT0   = 4'd0,
        POT1   = 4'd1,
        POT2   = 4'd2,
        POT3   = 4'd3,
        POT4   = 4'd4,
        POT5   = 4'd5,
        POT6   = 4'd6,
        POT7   = 4'd7,
        ALLPOT = 4'd8,   // unfinished lines
        KBCODE = 4'd9,   // last accepted key
        POTGO  = 4'd11,  // write only, starts a scan
        SKSTAT = 4'd15   // bit 2 is active low key down
    } reg_addr_e;

    // keyboard debounce
    typedef enum logic [1:0] {
        KEY_IDLE,   // nothing pending
        KEY_CHECK,  // candidate seen once
        KEY_HELD    // code accepted
    } key_state_e;

    // pot scan / dump control
    typedef enum logic [1:0] {
        POT_IDLE,  // just out of reset
        POT_SCAN,  // counting lines
        POT_DUMP   // caps held discharged
    } pot_state_e;

endpackage

// File: design/key_scanner.sv
/* keyboard matrix scanner with two pass debounce
   drives the scan code out, reads kr1_l back and keeps the accepted key code */
`timescale 1ns/1ps

module key_scanner (
    input  logic                              o2,
    input  logic                              rst,
    input  logic                              kr1_l,     // low while scanned key is down
    output logic [pokey_io_pkg::KEY_BITS-1:0] key_scan,
    output logic [pokey_io_pkg::KEY_BITS-1:0] kbcode,
    output logic                              key_down,
    output logic                              key_event
);
    import pokey_io_pkg::*;

    key_state_e          state;
    logic [KEY_BITS-1:0] scan_cnt;  // current matrix position
    logic [KEY_BITS-1:0] cmp_code;  // compare latch, candidate code
    logic                key_low;
    logic                at_cand;   // scan is back on the candidate slot

    assign key_scan = scan_cnt;
    assign key_low  = ~kr1_l;
    assign at_cand  = (scan_cnt == cmp_code);

    // free running scan, one code per o2
    always_ff @(posedge o2) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (scan_cnt == KEY_LAST) begin
            scan_cnt <= '0;  // wrap, new pass
        end else begin
            scan_cnt <= scan_cnt + KEY_BITS'(1);
        end
    end

    // first low seen while idle becomes the candidate
    always_ff @(posedge o2) begin
        if (state == KEY_IDLE && key_low) begin
            cmp_code <= scan_cnt;
        end
    end

    // debounce fsm
    always_ff @(posedge o2) begin
        if (rst) begin
            state     <= KEY_IDLE;
            kbcode    <= '0;
            key_down  <= 1'b0;
            key_event <= 1'b0;
        end else begin
            key_event <= 1'b0;  // single cycle pulse
            case (state)
                KEY_IDLE: begin
                    if (key_low) begin
                        state <= KEY_CHECK;  // wait one full pass
                    end
                end
                KEY_CHECK: begin
                    // only the candidate slot matters, other keys ignored
                    if (at_cand) begin
                        if (key_low) begin
                            state     <= KEY_HELD;
                            kbcode    <= scan_cnt;
                            key_down  <= 1'b1;
                            key_event <= 1'b1;
                        end else begin
                            state <= KEY_IDLE;  // bounce, drop it
                        end
                    end
                end
                KEY_HELD: begin
                    // release on first pass the slot reads high
                    if (at_cand && !key_low) begin
                        state    <= KEY_IDLE;
                        key_down <= 1'b0;  // kbcode keeps last key
                    end
                end
                default: begin
                    state <= KEY_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/pot_scanner.sv
/* paddle scanner, times eight pot lines against a line counter
   started by potgo_strobe, ends with every line latched and the dump output high */
`timescale 1ns/1ps

module pot_scanner (
    input  logic                                                           o2,
    input  logic                                                           rst,
    input  logic                                                           line_tick,
    input  logic                                                           potgo_strobe,
    input  logic [pokey_io_pkg::NUM_POTS-1:0]                              pot_in,
    output logic [pokey_io_pkg::NUM_POTS-1:0][pokey_io_pkg::POT_BITS-1:0] pot_val,
    output logic [pokey_io_pkg::NUM_POTS-1:0]                              allpot,
    output logic                                                           pot_dump
);
    import pokey_io_pkg::*;

    pot_state_e          state;
    logic [POT_BITS-1:0] line_cnt;   // lines since potgo
    logic                scan_tick;  // tick that counts during a scan
    logic                last_line;  // counter sits on POT_MAX
    logic [NUM_POTS-1:0] hit;        // lines latching on this tick

    assign scan_tick = (state == POT_SCAN) && line_tick;
    assign last_line = (line_cnt == POT_MAX);

    // open line that charged, or every open line on the final count
    assign hit = allpot & (pot_in | {NUM_POTS{last_line}});

    // scan / dump fsm
    always_ff @(posedge o2) begin
        if (rst) begin
            state    <= POT_IDLE;
            pot_dump <= 1'b1;  // caps discharged from power up
        end else if (potgo_strobe) begin
            state    <= POT_SCAN;  // also restarts a running scan
            pot_dump <= 1'b0;      // let the caps charge
        end else begin
            case (state)
                POT_IDLE: begin
                    state <= POT_DUMP;  // hold dump until the first potgo
                end
                POT_SCAN: begin
                    if (line_tick && last_line) begin
                        state    <= POT_DUMP;
                        pot_dump <= 1'b1;
                    end
                end
                POT_DUMP: begin
                    pot_dump <= 1'b1;
                end
                default: begin
                    state    <= POT_DUMP;
                    pot_dump <= 1'b1;
                end
            endcase
        end
    end

    // line counter, 0 .. POT_MAX
    always_ff @(posedge o2) begin
        if (rst) begin
            line_cnt <= '0;
        end else if (potgo_strobe) begin
            line_cnt <= '0;
        end else if (scan_tick && !last_line) begin
            line_cnt <= line_cnt + POT_BITS'(1);  // stops on POT_MAX
        end
    end

    // unfinished line mask
    always_ff @(posedge o2) begin
        if (rst) begin
            allpot <= '0;
        end else if (potgo_strobe) begin
            allpot <= '1;  // every line open
        end else if (scan_tick) begin
            allpot <= allpot & ~hit;  // all clear after last line
        end
    end

    // pot value latches, count captured once per line
    always_ff @(posedge o2) begin
        if (rst) begin
            pot_val <= '0;
        end else if (potgo_strobe) begin
            pot_val <= '0;
        end else if (scan_tick) begin
            for (int i = 0; i < NUM_POTS; i++) begin
                if (hit[i]) begin
                    pot_val[i] <= line_cnt;  // equals POT_MAX for lines never charged
                end
            end
        end
    end

endmodule

// File: design/io_regs.sv
/* cpu register port, decodes reads of pots, allpot, kbcode, skstat
   and turns a write to potgo into a one cycle start strobe */
`timescale 1ns/1ps

module io_regs (
    input  logic                                                           o2,
    input  logic                                                           rst,
    input  pokey_io_pkg::reg_addr_e                                        addr,
    input  logic                                                           rd,
    input  logic                                                           wr,
    input  logic [pokey_io_pkg::NUM_POTS-1:0][pokey_io_pkg::POT_BITS-1:0] pot_val,
    input  logic [pokey_io_pkg::NUM_POTS-1:0]                              allpot,
    input  logic [pokey_io_pkg::KEY_BITS-1:0]                              kbcode,
    input  logic                                                           key_down,
    output logic [7:0]                                                     rdata,
    output logic                                                           potgo_strobe
);
    import pokey_io_pkg::*;

    logic [7:0] rd_mux;  // value for the addressed register

    // read decode
    always_comb begin
        case (addr)
            POT0, POT1, POT2, POT3, POT4, POT5, POT6, POT7: begin
                rd_mux = pot_val[addr[2:0]];  // low bits pick the line
            end
            ALLPOT: begin
                rd_mux = allpot;
            end
            KBCODE: begin
                rd_mux = {{(8 - KEY_BITS){1'b0}}, kbcode};
            end
            SKSTAT: begin
                // bit 2 low while a key is held, rest read as ones
                rd_mux = {5'b11111, ~key_down, 2'b11};
            end
            default: begin
                rd_mux = 8'h00;  // potgo and unmapped addresses
            end
        endcase
    end

    // read data, valid the cycle after rd and held until the next read
    always_ff @(posedge o2) begin
        if (rst) begin
            rdata <= 8'h00;
        end else if (rd) begin
            rdata <= rd_mux;
        end
    end

    // potgo write, data ignored
    always_ff @(posedge o2) begin
        if (rst) begin
            potgo_strobe <= 1'b0;
        end else begin
            potgo_strobe <= wr && (addr == POTGO);  // other writes dropped
        end
    end

endmodule

// File: design/pokey_io.sv
/* top of the pokey i/o section
   ties the key scanner, pot scanner and cpu register port to pins and bus */
`timescale 1ns/1ps

module pokey_io (
    input  logic                              o2,
    input  logic                              rst,
    input  logic [3:0]                        addr,
    input  logic                              rd,
    input  logic                              wr,
    input  logic [7:0]                        wdata,     // bus width only, potgo ignores data
    input  logic                              kr1_l,
    input  logic [pokey_io_pkg::NUM_POTS-1:0] pot_in,
    input  logic                              line_tick,
    output logic [7:0]                        rdata,
    output logic [pokey_io_pkg::KEY_BITS-1:0] key_scan,
    output logic                              key_event,
    output logic                              pot_dump
);
    import pokey_io_pkg::*;

    logic [KEY_BITS-1:0]                kbcode;
    logic                               key_down;
    logic [NUM_POTS-1:0][POT_BITS-1:0] pot_val;
    logic [NUM_POTS-1:0]                allpot;
    logic                               potgo_strobe;  // io_regs to pot_scanner

    key_scanner u_key_scanner (
        .o2        (o2),
        .rst       (rst),
        .kr1_l     (kr1_l),
        .key_scan  (key_scan),
        .kbcode    (kbcode),
        .key_down  (key_down),
        .key_event (key_event)
    );

    pot_scanner u_pot_scanner (
        .o2           (o2),
        .rst          (rst),
        .line_tick    (line_tick),
        .potgo_strobe (potgo_strobe),
        .pot_in       (pot_in),
        .pot_val      (pot_val),
        .allpot       (allpot),
        .pot_dump     (pot_dump)
    );

    io_regs u_io_regs (
        .o2           (o2),
        .rst          (rst),
        .addr         (reg_addr_e'(addr)),
        .rd           (rd),
        .wr           (wr),
        .pot_val      (pot_val),
        .allpot       (allpot),
        .kbcode       (kbcode),
        .key_down     (key_down),
        .rdata        (rdata),
        .potgo_strobe (potgo_strobe)
    );

endmodule

// File: verification/clock_gen.sv
/* o2 clock for the testbench, 40 ns period
   rst held high for the first 8 cycles, released on a falling edge */
`timescale 1ns/1ps

module clock_gen (
    output logic o2,
    output logic rst
);

    initial begin
        o2 = 1'b0;
        forever #20 o2 = ~o2;  // 20 ns high, 20 ns low
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge o2);  // 8 reset cycles
        @(negedge o2);
        rst <= 1'b0;
    end

endmodule

// File: verification/pokey_io_properties.sv
/* concurrent checks on pokey_io ports and internal strobes
   bound into pokey_io, any failing check also sets failed */
`timescale 1ns/1ps

module pokey_io_properties (
    input logic                              o2,
    input logic                              rst,
    input logic                              rd,
    input logic [7:0]                        rdata,
    input logic [pokey_io_pkg::KEY_BITS-1:0] key_scan,
    input logic                              key_event,
    input logic                              key_down,
    input logic                              pot_dump,
    input logic                              potgo_strobe,
    input logic [pokey_io_pkg::NUM_POTS-1:0] allpot
);
    import pokey_io_pkg::*;

    logic f_reset = 1'b0;
    logic f_potgo = 1'b0;
    logic f_hold  = 1'b0;
    logic f_rise  = 1'b0;
    logic f_event = 1'b0;
    logic f_rdata = 1'b0;
    logic f_scan  = 1'b0;
    logic failed;

    assign failed = f_reset | f_potgo | f_hold | f_rise | f_event | f_rdata | f_scan;

    // first cycle out of reset, caps dumped, no key, bus quiet
    a_reset_state: assert property (@(posedge o2)
        $fell(rst) |-> pot_dump && !key_event && rdata == 8'h00)
        else begin f_reset = 1'b1; $error("outputs not in reset state after reset"); end

    // potgo strobe opens every line and lets the caps charge
    a_potgo_start: assert property (@(posedge o2) disable iff (rst)
        potgo_strobe |=> !pot_dump && allpot == '1)
        else begin f_potgo = 1'b1; $error("scan did not start one cycle after potgo"); end

    // dump stays on until the next potgo
    a_dump_hold: assert property (@(posedge o2) disable iff (rst)
        pot_dump && !potgo_strobe |=> pot_dump)
        else begin f_hold = 1'b1; $error("pot_dump dropped without potgo"); end

    a_dump_rise: assert property (@(posedge o2) disable iff (rst)
        $rose(pot_dump) |-> allpot == '0)  // only at scan end
        else begin f_rise = 1'b1; $error("pot_dump rose with lines still open"); end

    // one event per accepted key, never while held
    a_event_once: assert property (@(posedge o2) disable iff (rst)
        key_event |-> $rose(key_down))
        else begin f_event = 1'b1; $error("key_event without a new key going down"); end

    a_rdata_hold: assert property (@(posedge o2) disable iff (rst)
        !rd |=> $stable(rdata))  // held until next read
        else begin f_rdata = 1'b1; $error("rdata changed without a read"); end

    // scan code steps by one per o2, wraps after 63
    a_scan_step: assert property (@(posedge o2)
        !rst |=> key_scan == $past(key_scan) + KEY_BITS'(1))
        else begin f_scan = 1'b1; $error("key_scan did not advance by one"); end

endmodule

bind pokey_io pokey_io_properties u_props (
    .o2           (o2),
    .rst          (rst),
    .rd           (rd),
    .rdata        (rdata),
    .key_scan     (key_scan),
    .key_event    (key_event),
    .key_down     (key_down),
    .pot_dump     (pot_dump),
    .potgo_strobe (potgo_strobe),
    .allpot       (allpot)
);

// File: verification/tb_pokey_io.sv
/* testbench for pokey_io, models the key matrix and the paddles
   runs pot scans, key accept, hold, release and bounce through the cpu port */
`timescale 1ns/1ps

module tb_pokey_io;
    import pokey_io_pkg::*;

    logic                o2;
    logic                rst;
    logic [3:0]          addr;
    logic                rd;
    logic                wr;
    logic [7:0]          wdata;
    logic                kr1_l = 1'b1;
    logic [NUM_POTS-1:0] pot_in = '0;
    logic                line_tick = 1'b0;
    logic [7:0]          rdata;
    logic [KEY_BITS-1:0] key_scan;
    logic                key_event;
    logic                pot_dump;

    logic [15:0]         lfsr = 16'd52;      // seed
    int                  target [NUM_POTS];  // paddle charge time in lines
    logic [KEY_BITS-1:0] key_a;
    logic [KEY_BITS-1:0] key_b;
    logic [KEY_BITS-1:0] key_c;              // bounce key
    logic                a_down = 1'b0;
    logic                b_down = 1'b0;
    int                  bounce_req = 0;
    int                  bounce_seen = 0;
    int                  tick_div = 0;
    int                  tick_count = 0;     // lines counted since potgo
    logic                start_wait = 1'b0;
    logic                counting = 1'b0;
    logic [NUM_POTS-1:0] charged = '0;
    int                  event_count = 0;
    int                  cycles = 0;
    // 4 scans of 229 lines at 3 cycles, 20 key passes, margin
    int                  timeout_limit = 4 * (int'(POT_MAX) + 1) * 3 + 20 * 64 + 1000;

    clock_gen u_clk (
        .o2  (o2),
        .rst (rst)
    );

    pokey_io UUT (
        .o2        (o2),
        .rst       (rst),
        .addr      (addr),
        .rd        (rd),
        .wr        (wr),
        .wdata     (wdata),
        .kr1_l     (kr1_l),
        .pot_in    (pot_in),
        .line_tick (line_tick),
        .rdata     (rdata),
        .key_scan  (key_scan),
        .key_event (key_event),
        .pot_dump  (pot_dump)
    );

    // one tv line every 3 o2
    always @(negedge o2) begin
        if (rst) begin
            tick_div  <= 0;
            line_tick <= 1'b0;
        end else begin
            tick_div  <= (tick_div == 2) ? 0 : tick_div + 1;
            line_tick <= (tick_div == 2);
        end
    end

    // key matrix, return line low while a pressed key is scanned
    always @(negedge o2) begin
        logic down;
        down = (a_down && key_scan == key_a) || (b_down && key_scan == key_b);
        if (bounce_req != bounce_seen && key_scan == key_c) begin
            down = 1'b1;  // single cycle contact
            bounce_seen <= bounce_req;
        end
        kr1_l <= ~down;
    end

    // paddles, count the lines the scanner sees after potgo
    always @(posedge o2) begin
        if (wr && addr == POTGO) begin
            tick_count = 0;
            counting   = 1'b0;
            start_wait = 1'b1;  // strobe now, scan state next edge
        end else if (start_wait) begin
            start_wait = 1'b0;
            counting   = 1'b1;
        end else if (counting && line_tick) begin
            tick_count = tick_count + 1;
        end
        for (int i = 0; i < NUM_POTS; i++) begin
            charged[i] = counting && (tick_count >= target[i]);
        end
    end

    always @(negedge o2) begin
        pot_in <= charged;
    end

    always @(posedge o2) begin
        if (key_event) begin
            event_count <= event_count + 1;
        end
    end

    // watchdog and property flag
    always @(negedge o2) begin
        cycles <= cycles + 1;
        if (UUT.u_props.failed) begin
            $display("a concurrent check on pokey_io failed");
            stop_on_failure();
        end else if (cycles >= timeout_limit) begin
            $display("timeout, run still going after %0d cycles", timeout_limit);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual == expected) else begin
            $display("ERR %s expected %02h actual %02h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = val * 2 + int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);  // one step per bit
        end
    endtask

    task automatic write_reg(input reg_addr_e a);
        addr  = a;
        wdata = 8'h5a;
        wr    = 1'b1;
        @(negedge o2);
        wr    = 1'b0;
    endtask

    task automatic read_expect(input reg_addr_e a, input logic [7:0] expected,
                               input string name);
        addr = a;
        rd   = 1'b1;
        @(negedge o2);
        rd   = 1'b0;
        check_byte(name, expected, rdata);  // captured on the edge just gone
    endtask

    task automatic set_keys(input logic a_on, input logic b_on);
        @(posedge o2);
        a_down = a_on;
        b_down = b_on;
        @(negedge o2);
    endtask

    task automatic run_pot_scan(input int beyond, input bit restart);
        logic [7:0] expected;
        for (int i = 0; i < NUM_POTS; i++) begin
            take_bits(POT_BITS, target[i]);
        end
        target[beyond] = int'(POT_MAX) + 12;  // never charges within a scan
        write_reg(POTGO);
        if (restart) begin
            repeat (90) @(negedge o2);  // about 30 lines in
            write_reg(POTGO);
        end
        @(negedge o2);
        read_expect(ALLPOT, 8'hff, "potgo_allpot");
        while (!pot_dump) @(negedge o2);  // scan end
        for (int i = 0; i < NUM_POTS; i++) begin
            expected = (target[i] > int'(POT_MAX)) ? POT_MAX : 8'(target[i]);
            read_expect(reg_addr_e'(4'(i)), expected, $sformatf("pot%0d", i));
        end
        read_expect(ALLPOT, 8'h00, "scan_end_allpot");
    endtask

    initial begin
        int code;
        addr  = 4'd0;
        rd    = 1'b0;
        wr    = 1'b0;
        wdata = 8'h00;
        take_bits(KEY_BITS, code);
        key_a = KEY_BITS'(code);
        key_b = key_a ^ 6'h15;
        key_c = key_a ^ 6'h2a;
        @(negedge o2);
        while (rst) @(negedge o2);

        for (int i = 0; i < NUM_POTS; i++) begin
            read_expect(reg_addr_e'(4'(i)), 8'h00, $sformatf("reset_pot%0d", i));
        end
        read_expect(ALLPOT, 8'h00, "reset_allpot");
        read_expect(KBCODE, 8'h00, "reset_kbcode");
        read_expect(SKSTAT, 8'hff, "reset_skstat");

        run_pot_scan(5, 1'b0);
        run_pot_scan(2, 1'b0);
        run_pot_scan(7, 1'b1);  // potgo again mid scan

        // key held for three passes
        set_keys(1'b1, 1'b0);
        while (event_count == 0) @(negedge o2);
        repeat (64) @(negedge o2);
        check_byte("key_accept_events", 8'd1, 8'(event_count));
        read_expect(KBCODE, 8'(key_a), "key_accept_kbcode");
        read_expect(SKSTAT, 8'hfb, "key_accept_skstat");

        set_keys(1'b1, 1'b1);  // second key while first held
        repeat (3 * 64) @(negedge o2);
        check_byte("second_key_events", 8'd1, 8'(event_count));
        set_keys(1'b1, 1'b0);
        set_keys(1'b0, 1'b0);
        repeat (2 * 64) @(negedge o2);
        read_expect(SKSTAT, 8'hff, "release_skstat");

        // one cycle bounce on key_c
        @(posedge o2);
        bounce_req = bounce_req + 1;
        @(negedge o2);
        repeat (3 * 64) @(negedge o2);
        check_byte("bounce_events", 8'd1, 8'(event_count));
        read_expect(KBCODE, 8'(key_a), "bounce_kbcode");

        if (!UUT.u_props.failed) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// File: filelist.f
design/pokey_io_pkg.sv
design/key_scanner.sv
design/pot_scanner.sv
design/io_regs.sv
design/pokey_io.sv
verification/clock_gen.sv
verification/pokey_io_properties.sv
verification/tb_pokey_io.sv

// File: Makefile
# verilator build and run of the pokey i/o testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module tb_pokey_io -f filelist.f
	./obj_dir/Vtb_pokey_io +verilator+error+limit+100 | \
		awk '{ print } /Done: no errors/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
